// File: verilog/cdp_dp_pkg.sv
/*
  cdp datapath package
  stream payload layout, fp16 field positions, counter width
  and the state encoding of the nan preprocessing stage
*/
`default_nettype none

package cdp_dp_pkg;

  //////////////////////////////
  // stream geometry
  //////////////////////////////
  // elements per beat
  localparam int cdp_throughput = 4;
  // bits per element, fp16 only
  localparam int cdp_bpe = 16;
  // data part of the payload
  localparam int cdp_dat_w = cdp_throughput * cdp_bpe;
  // data + 3 last flags + 5 bit tag
  localparam int cdp_pd_w = 72;

  // flag positions above the data
  localparam int cdp_last_w_bit = 64;
  localparam int cdp_last_h_bit = 65;
  localparam int cdp_last_c_bit = 66;

  //////////////////////////////
  // fp16 fields
  //////////////////////////////
  localparam int fp16_exp_msb = 14;
  localparam int fp16_exp_lsb = 10;
  // mantissa runs down to bit 0
  localparam int fp16_man_msb = 9;

  // nan / inf statistics counters
  localparam int cdp_cnt_w = 32;

  // input gating around layers
  typedef enum logic {
    st_wait_op_en = 1'b0,
    st_active     = 1'b1
  } nan_state_e;

endpackage

`default_nettype wire

// File: verilog/cdp_reg_pkg.sv
/*
  cdp register package
  axi4-lite register map, response codes and bus widths
*/
`default_nettype none

package cdp_reg_pkg;

  // byte address of the register window
  localparam int cdp_reg_addr_w = 5;
  // full words only, no strobes
  localparam int cdp_axi_data_w = 32;

  // register offsets
  typedef enum logic [cdp_reg_addr_w-1:0] {
    reg_op_enable     = 5'h00,
    reg_nan_to_zero   = 5'h04,
    reg_nan_input_num = 5'h08,
    reg_inf_input_num = 5'h0C,
    reg_status        = 5'h10
  } cdp_reg_e;

  // axi response codes in use
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// File: verilog/cdp_dp_nan.sv
/*
  cdp nan preprocessing stage
  gates input around layers on op_en, optionally flushes fp16
  nan elements to zero, classifies nan/inf per beat and passes
  beats on through one output register
*/
`timescale 1ns/1ps
`default_nettype none

module cdp_dp_nan (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  logic                            cdp_rdma2dp_valid,
  input  logic [cdp_dp_pkg::cdp_pd_w-1:0] cdp_rdma2dp_pd,
  output logic                            cdp_rdma2dp_ready,
  output logic                            nan_preproc_pvld,
  output logic [cdp_dp_pkg::cdp_pd_w-1:0] nan_preproc_pd,
  input  logic                            nan_preproc_prdy,
  input  logic                            reg2dp_op_en,
  input  logic                            reg2dp_nan_to_zero,
  output logic                            beat_load,
  output logic [2:0]                      nan_num,
  output logic [2:0]                      inf_num,
  output logic                            cube_end,
  output logic                            layer_done
);
  import cdp_dp_pkg::*;

  nan_state_e                state;
  logic                      op_en_d1;
  logic                      op_en_rise;
  logic [cdp_throughput-1:0] dat_is_nan;
  logic [cdp_throughput-1:0] dat_is_inf;
  logic [cdp_dat_w-1:0]      din_dat;

  // population count of a per-element flag vector
  function automatic logic [2:0] bit_sum(input logic [cdp_throughput-1:0] flags);
    logic [2:0] sum;
    sum = '0;
    for (int i = 0; i < cdp_throughput; i++) begin
      sum = sum + 3'(flags[i]);
    end
    return sum;
  endfunction

  //////////////////////////////
  // per-element classification
  //////////////////////////////
  for (genvar g = 0; g < cdp_throughput; g++) begin : g_elem
    logic [cdp_bpe-1:0] elem;
    logic               exp_ones;
    logic               man_nz;

    assign elem     = cdp_rdma2dp_pd[g*cdp_bpe +: cdp_bpe];
    assign exp_ones = &elem[fp16_exp_msb:fp16_exp_lsb];
    assign man_nz   = |elem[fp16_man_msb:0];

    assign dat_is_nan[g] = exp_ones & man_nz;
    assign dat_is_inf[g] = exp_ones & ~man_nz;
    // sign bit cleared as well so nan becomes +0
    assign din_dat[g*cdp_bpe +: cdp_bpe] =
      (dat_is_nan[g] & reg2dp_nan_to_zero) ? '0 : elem;
  end

  assign nan_num  = bit_sum(dat_is_nan);
  assign inf_num  = bit_sum(dat_is_inf);
  // last beat of the cube carries all three flags
  assign cube_end = cdp_rdma2dp_pd[cdp_last_w_bit] & cdp_rdma2dp_pd[cdp_last_h_bit] &
                    cdp_rdma2dp_pd[cdp_last_c_bit];

  //////////////////////////////
  // layer gating
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_d1 <= 1'b0;
    end else begin
      op_en_d1 <= reg2dp_op_en;
    end
  end

  // only a fresh enable reopens the input
  assign op_en_rise = reg2dp_op_en & ~op_en_d1;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= st_wait_op_en;
    end else if (beat_load & cube_end) begin
      state <= st_wait_op_en;
    end else if (op_en_rise) begin
      state <= st_active;
    end
  end

  // accept when open and the output slot is free or draining
  assign cdp_rdma2dp_ready = (state == st_active) & (~nan_preproc_pvld | nan_preproc_prdy);
  assign beat_load         = cdp_rdma2dp_valid & cdp_rdma2dp_ready;

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_preproc_pvld <= 1'b0;
    end else if (beat_load) begin
      nan_preproc_pvld <= 1'b1;
    end else if (nan_preproc_prdy) begin
      nan_preproc_pvld <= 1'b0;
    end
  end

  // flags and tag copied as they come
  always_ff @(posedge nvdla_core_clk) begin
    if (beat_load) begin
      nan_preproc_pd <= {cdp_rdma2dp_pd[cdp_pd_w-1:cdp_dat_w], din_dat};
    end
  end

  // cube end leaving the stage closes the layer
  assign layer_done = nan_preproc_pvld & nan_preproc_prdy & nan_preproc_pd[cdp_last_w_bit] &
                      nan_preproc_pd[cdp_last_h_bit] & nan_preproc_pd[cdp_last_c_bit];

  // stalled output keeps its beat
  a_out_stable : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    nan_preproc_pvld && !nan_preproc_prdy |=> nan_preproc_pvld && $stable(nan_preproc_pd)
  );

  // closed stage stays shut until a fresh enable
  a_no_load_closed : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    state == st_wait_op_en && !op_en_rise |=> !beat_load
  );

endmodule

`default_nettype wire

// File: verilog/cdp_dp_nan_count.sv
/*
  cdp nan/inf statistics
  accumulates per-layer nan and inf element counts and publishes
  them ping-pong style when the layer completes downstream
*/
`timescale 1ns/1ps
`default_nettype none

module cdp_dp_nan_count (
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  input  logic                             beat_load,
  input  logic [2:0]                       nan_num,
  input  logic [2:0]                       inf_num,
  input  logic                             cube_end,
  input  logic                             layer_done,
  output logic [cdp_dp_pkg::cdp_cnt_w-1:0] dp2reg_nan_input_num,
  output logic [cdp_dp_pkg::cdp_cnt_w-1:0] dp2reg_inf_input_num
);
  import cdp_dp_pkg::*;

  logic [cdp_cnt_w-1:0] nan_cnt;
  logic [cdp_cnt_w-1:0] inf_cnt;
  logic [cdp_cnt_w-1:0] nan_sum;
  logic [cdp_cnt_w-1:0] inf_sum;
  logic [cdp_cnt_w-1:0] nan_slot [2];
  logic [cdp_cnt_w-1:0] inf_slot [2];
  logic                 layer_flag;
  logic                 done_flag;
  logic [1:0]           pend_cnt;
  logic                 save;

  // running total including the current beat
  assign nan_sum = nan_cnt + cdp_cnt_w'(nan_num);
  assign inf_sum = inf_cnt + cdp_cnt_w'(inf_num);
  assign save    = beat_load & cube_end;

  //////////////////////////////
  // running counters
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_cnt    <= '0;
      inf_cnt    <= '0;
      layer_flag <= 1'b0;
    end else if (save) begin
      nan_cnt    <= '0;
      inf_cnt    <= '0;
      layer_flag <= ~layer_flag;
    end else if (beat_load) begin
      nan_cnt <= nan_sum;
      inf_cnt <= inf_sum;
    end
  end

  // ping or pong slot, picked by layer_flag
  always_ff @(posedge nvdla_core_clk) begin
    if (save) begin
      nan_slot[layer_flag] <= nan_sum;
      inf_slot[layer_flag] <= inf_sum;
    end
  end

  //////////////////////////////
  // publish on completion
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_flag            <= 1'b0;
      dp2reg_nan_input_num <= '0;
      dp2reg_inf_input_num <= '0;
    end else if (layer_done) begin
      done_flag            <= ~done_flag;
      dp2reg_nan_input_num <= nan_slot[done_flag];
      dp2reg_inf_input_num <= inf_slot[done_flag];
    end
  end

  // saved layers not yet published
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pend_cnt <= '0;
    end else begin
      pend_cnt <= pend_cnt + 2'(save) - 2'(layer_done);
    end
  end

  a_done_pending : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    layer_done |-> pend_cnt != 2'd0
  );

endmodule

`default_nettype wire

// File: verilog/cdp_reg_slave.sv
/*
  cdp register block
  axi4-lite slave holding op enable, nan-to-zero mode, the
  published nan/inf counts and a sticky layer done flag
*/
`timescale 1ns/1ps
`default_nettype none

module cdp_reg_slave (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [cdp_reg_pkg::cdp_reg_addr_w-1:0] awaddr,
  input  logic                                  wvalid,
  output logic                                  wready,
  input  logic [cdp_reg_pkg::cdp_axi_data_w-1:0] wdata,
  output logic                                  bvalid,
  input  logic                                  bready,
  output cdp_reg_pkg::axi_resp_e                bresp,
  input  logic                                  arvalid,
  output logic                                  arready,
  input  logic [cdp_reg_pkg::cdp_reg_addr_w-1:0] araddr,
  output logic                                  rvalid,
  input  logic                                  rready,
  output logic [cdp_reg_pkg::cdp_axi_data_w-1:0] rdata,
  output cdp_reg_pkg::axi_resp_e                rresp,
  output logic                                  reg2dp_op_en,
  output logic                                  reg2dp_nan_to_zero,
  input  logic [cdp_dp_pkg::cdp_cnt_w-1:0]      dp2reg_nan_input_num,
  input  logic [cdp_dp_pkg::cdp_cnt_w-1:0]      dp2reg_inf_input_num,
  input  logic                                  dp2reg_done
);
  import cdp_reg_pkg::*;

  logic                      wr_take;
  logic                      rd_take;
  logic                      status_done;
  axi_resp_e                 wr_resp;
  axi_resp_e                 rd_resp;
  logic [cdp_axi_data_w-1:0] rd_data;

  // one outstanding access per channel
  assign wr_take = awvalid & wvalid & ~bvalid;
  assign rd_take = arvalid & ~rvalid;
  assign awready = wr_take;
  assign wready  = wr_take;
  assign arready = rd_take;

  // count registers are read only
  always_comb begin
    case (awaddr)
      reg_op_enable, reg_nan_to_zero, reg_status: wr_resp = resp_okay;
      default:                                    wr_resp = resp_slverr;
    endcase
  end

  always_comb begin
    rd_resp = resp_okay;
    case (araddr)
      reg_op_enable:     rd_data = cdp_axi_data_w'(reg2dp_op_en);
      reg_nan_to_zero:   rd_data = cdp_axi_data_w'(reg2dp_nan_to_zero);
      reg_nan_input_num: rd_data = cdp_axi_data_w'(dp2reg_nan_input_num);
      reg_inf_input_num: rd_data = cdp_axi_data_w'(dp2reg_inf_input_num);
      reg_status:        rd_data = cdp_axi_data_w'(status_done);
      default: begin
        rd_data = '0;
        rd_resp = resp_slverr;
      end
    endcase
  end

  //////////////////////////////
  // register state
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reg2dp_op_en       <= 1'b0;
      reg2dp_nan_to_zero <= 1'b0;
      status_done        <= 1'b0;
    end else begin
      // layer completion drops enable, flags done
      if (dp2reg_done) begin
        reg2dp_op_en <= 1'b0;
        status_done  <= 1'b1;
      end
      if (wr_take) begin
        case (awaddr)
          reg_op_enable:   reg2dp_op_en <= wdata[0];
          reg_nan_to_zero: reg2dp_nan_to_zero <= wdata[0];
          // write 1 to clear, a new done wins
          reg_status: begin
            if (wdata[0] && !dp2reg_done) begin
              status_done <= 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // response channels
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_take) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_take) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_take) begin
      bresp <= wr_resp;
    end
    if (rd_take) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  a_bvalid_hold : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

  a_rvalid_hold : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  );

endmodule

`default_nettype wire

// File: verilog/cdp_dp_top.sv
/*
  cdp datapath front end
  register block, nan preprocessing stage and nan/inf statistics
*/
`timescale 1ns/1ps
`default_nettype none

module cdp_dp_top (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [cdp_reg_pkg::cdp_reg_addr_w-1:0] awaddr,
  input  logic                                  wvalid,
  output logic                                  wready,
  input  logic [cdp_reg_pkg::cdp_axi_data_w-1:0] wdata,
  output logic                                  bvalid,
  input  logic                                  bready,
  output cdp_reg_pkg::axi_resp_e                bresp,
  input  logic                                  arvalid,
  output logic                                  arready,
  input  logic [cdp_reg_pkg::cdp_reg_addr_w-1:0] araddr,
  output logic                                  rvalid,
  input  logic                                  rready,
  output logic [cdp_reg_pkg::cdp_axi_data_w-1:0] rdata,
  output cdp_reg_pkg::axi_resp_e                rresp,
  input  logic                                  cdp_rdma2dp_valid,
  output logic                                  cdp_rdma2dp_ready,
  input  logic [cdp_dp_pkg::cdp_pd_w-1:0]       cdp_rdma2dp_pd,
  output logic                                  nan_preproc_pvld,
  input  logic                                  nan_preproc_prdy,
  output logic [cdp_dp_pkg::cdp_pd_w-1:0]       nan_preproc_pd
);
  import cdp_dp_pkg::*;

  // config from the register block
  logic                 reg2dp_op_en;
  logic                 reg2dp_nan_to_zero;
  // per-beat statistics
  logic                 beat_load;
  logic [2:0]           nan_num;
  logic [2:0]           inf_num;
  logic                 cube_end;
  logic                 layer_done;
  // published counts
  logic [cdp_cnt_w-1:0] dp2reg_nan_input_num;
  logic [cdp_cnt_w-1:0] dp2reg_inf_input_num;

  cdp_reg_slave u_reg (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .awvalid             (awvalid),
    .awready             (awready),
    .awaddr              (awaddr),
    .wvalid              (wvalid),
    .wready              (wready),
    .wdata               (wdata),
    .bvalid              (bvalid),
    .bready              (bready),
    .bresp               (bresp),
    .arvalid             (arvalid),
    .arready             (arready),
    .araddr              (araddr),
    .rvalid              (rvalid),
    .rready              (rready),
    .rdata               (rdata),
    .rresp               (rresp),
    .reg2dp_op_en        (reg2dp_op_en),
    .reg2dp_nan_to_zero  (reg2dp_nan_to_zero),
    .dp2reg_nan_input_num(dp2reg_nan_input_num),
    .dp2reg_inf_input_num(dp2reg_inf_input_num),
    .dp2reg_done         (layer_done)
  );

  cdp_dp_nan u_nan (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .cdp_rdma2dp_valid (cdp_rdma2dp_valid),
    .cdp_rdma2dp_pd    (cdp_rdma2dp_pd),
    .cdp_rdma2dp_ready (cdp_rdma2dp_ready),
    .nan_preproc_pvld  (nan_preproc_pvld),
    .nan_preproc_pd    (nan_preproc_pd),
    .nan_preproc_prdy  (nan_preproc_prdy),
    .reg2dp_op_en      (reg2dp_op_en),
    .reg2dp_nan_to_zero(reg2dp_nan_to_zero),
    .beat_load         (beat_load),
    .nan_num           (nan_num),
    .inf_num           (inf_num),
    .cube_end          (cube_end),
    .layer_done        (layer_done)
  );

  cdp_dp_nan_count u_nan_count (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .beat_load           (beat_load),
    .nan_num             (nan_num),
    .inf_num             (inf_num),
    .cube_end            (cube_end),
    .layer_done          (layer_done),
    .dp2reg_nan_input_num(dp2reg_nan_input_num),
    .dp2reg_inf_input_num(dp2reg_inf_input_num)
  );

endmodule

`default_nettype wire

// File: verif/tb_cdp_dp.sv
/*
  testbench for the cdp datapath front end
  replays register accesses, beats and layer markers from the cases
  file and checks bus responses, stream output and published counts
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cdp_dp;
  import cdp_dp_pkg::*;
  import cdp_reg_pkg::*;

  // per-wait cycle limits
  localparam int axi_timeout   = 50;
  localparam int layer_timeout = 2000;
  // quiet cycles checked after a layer drains
  localparam int settle_cycles = 4;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      awvalid;
  logic                      awready;
  logic [cdp_reg_addr_w-1:0] awaddr;
  logic                      wvalid;
  logic                      wready;
  logic [cdp_axi_data_w-1:0] wdata;
  logic                      bvalid;
  logic                      bready;
  logic [1:0]                bresp;
  logic                      arvalid;
  logic                      arready;
  logic [cdp_reg_addr_w-1:0] araddr;
  logic                      rvalid;
  logic                      rready;
  logic [cdp_axi_data_w-1:0] rdata;
  logic [1:0]                rresp;
  logic                      cdp_rdma2dp_valid;
  logic                      cdp_rdma2dp_ready;
  logic [cdp_pd_w-1:0]       cdp_rdma2dp_pd;
  logic                      nan_preproc_pvld;
  logic                      nan_preproc_prdy;
  logic [cdp_pd_w-1:0]       nan_preproc_pd;

  // beats of the current layer and their expected outputs
  logic [cdp_pd_w-1:0] in_q [$];
  logic [cdp_pd_w-1:0] exp_q [$];
  logic [7:0]          lfsr;
  int                  err_cnt;
  int                  test_cnt;
  int                  pass_cnt;
  int                  fail_cnt;
  logic                run_aborted;

  cdp_dp_top i_dut (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .awvalid          (awvalid),
    .awready          (awready),
    .awaddr           (awaddr),
    .wvalid           (wvalid),
    .wready           (wready),
    .wdata            (wdata),
    .bvalid           (bvalid),
    .bready           (bready),
    .bresp            (bresp),
    .arvalid          (arvalid),
    .arready          (arready),
    .araddr           (araddr),
    .rvalid           (rvalid),
    .rready           (rready),
    .rdata            (rdata),
    .rresp            (rresp),
    .cdp_rdma2dp_valid(cdp_rdma2dp_valid),
    .cdp_rdma2dp_ready(cdp_rdma2dp_ready),
    .cdp_rdma2dp_pd   (cdp_rdma2dp_pd),
    .nan_preproc_pvld (nan_preproc_pvld),
    .nan_preproc_prdy (nan_preproc_prdy),
    .nan_preproc_pd   (nan_preproc_pd)
  );

  // 40 ns period
  always #20 nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////
  // helpers
  //////////////////////////////
  // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    logic fb;
    fb = s[7] ^ s[5] ^ s[4] ^ s[3];
    return {s[6:0], fb};
  endfunction

  // rest of a comment line
  task automatic skip_comment(input int fd);
    int c;
    c = 0;
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic report_test(input string what, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before && !run_aborted) begin
      pass_cnt++;
      $display("test %0d %s: ok", test_cnt, what);
    end else begin
      fail_cnt++;
      $display("test %0d %s: bad", test_cnt, what);
    end
  endtask

  // inputs change at posedge + 2, sampled on the negedge before the handshake edge
  task automatic write_reg(input logic [cdp_reg_addr_w-1:0] addr,
                           input logic [cdp_axi_data_w-1:0] data, output logic [1:0] resp);
    int cyc;
    bit taken;
    resp    = 2'bxx;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    taken   = 1'b0;
    cyc     = 0;
    while (!taken && !run_aborted) begin
      @(negedge nvdla_core_clk);
      taken = awready && wready;
      @(posedge nvdla_core_clk);
      #2;
      cyc++;
      if (!taken && cyc >= axi_timeout) begin
        $display("timeout: write to 0x%02h was never accepted", addr);
        run_aborted = 1'b1;
      end
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    taken   = 1'b0;
    cyc     = 0;
    // bready already high, response taken on the next edge
    while (!taken && !run_aborted) begin
      @(negedge nvdla_core_clk);
      if (bvalid) begin
        taken = 1'b1;
        resp  = bresp;
      end
      @(posedge nvdla_core_clk);
      #2;
      cyc++;
      if (!taken && cyc >= axi_timeout) begin
        $display("timeout: no write response for 0x%02h", addr);
        run_aborted = 1'b1;
      end
    end
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [cdp_reg_addr_w-1:0] addr,
                          output logic [cdp_axi_data_w-1:0] data, output logic [1:0] resp);
    int cyc;
    bit taken;
    data    = 'x;
    resp    = 2'bxx;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    taken   = 1'b0;
    cyc     = 0;
    while (!taken && !run_aborted) begin
      @(negedge nvdla_core_clk);
      taken = arready;
      @(posedge nvdla_core_clk);
      #2;
      cyc++;
      if (!taken && cyc >= axi_timeout) begin
        $display("timeout: read of 0x%02h was never accepted", addr);
        run_aborted = 1'b1;
      end
    end
    arvalid = 1'b0;
    taken   = 1'b0;
    cyc     = 0;
    while (!taken && !run_aborted) begin
      @(negedge nvdla_core_clk);
      if (rvalid) begin
        taken = 1'b1;
        data  = rdata;
        resp  = rresp;
      end
      @(posedge nvdla_core_clk);
      #2;
      cyc++;
      if (!taken && cyc >= axi_timeout) begin
        $display("timeout: no read data for 0x%02h", addr);
        run_aborted = 1'b1;
      end
    end
    rready = 1'b0;
  endtask

  //////////////////////////////
  // one layer through the stream
  //////////////////////////////
  task automatic run_layer(input int gate_cycles, input int stall);
    int          cyc;
    int          sent;
    bit          in_fire;
    bit          out_fire;
    logic [1:0]  resp;
    logic [cdp_pd_w-1:0] exp_pd;
    // closed stage must not take the first beat
    cdp_rdma2dp_valid = 1'b1;
    cdp_rdma2dp_pd    = in_q[0];
    for (cyc = 0; cyc < gate_cycles; cyc++) begin
      @(negedge nvdla_core_clk);
      if (cdp_rdma2dp_ready) begin
        $display("[ERROR] %0t: input ready high before op_enable write", $time);
        err_cnt++;
      end
      @(posedge nvdla_core_clk);
      #2;
    end
    cdp_rdma2dp_valid = 1'b0;
    write_reg(reg_op_enable, 32'h1, resp);
    if (!run_aborted && resp !== resp_okay) begin
      $display("[ERROR] %0t: op_enable write bresp %0d", $time, resp);
      err_cnt++;
    end
    sent = 0;
    cyc  = 0;
    while ((sent < in_q.size() || exp_q.size() > 0) && !run_aborted) begin
      // valid never waits on ready
      if (sent < in_q.size()) begin
        cdp_rdma2dp_valid = 1'b1;
        cdp_rdma2dp_pd    = in_q[sent];
      end else begin
        cdp_rdma2dp_valid = 1'b0;
      end
      if (stall != 0) begin
        lfsr             = lfsr_next(lfsr);
        nan_preproc_prdy = lfsr[0];
      end else begin
        nan_preproc_prdy = 1'b1;
      end
      @(negedge nvdla_core_clk);
      in_fire  = cdp_rdma2dp_valid && cdp_rdma2dp_ready;
      out_fire = nan_preproc_pvld && nan_preproc_prdy;
      if (out_fire) begin
        if (exp_q.size() == 0) begin
          $display("[ERROR] %0t: output beat %h with none expected", $time, nan_preproc_pd);
          err_cnt++;
        end else begin
          exp_pd = exp_q.pop_front();
          if (nan_preproc_pd !== exp_pd) begin
            $display("[ERROR] %0t: output %h, expected %h", $time, nan_preproc_pd, exp_pd);
            err_cnt++;
          end
        end
      end
      @(posedge nvdla_core_clk);
      #2;
      if (in_fire) begin
        sent++;
      end
      cyc++;
      if (cyc >= layer_timeout) begin
        $display("timeout: layer stuck with %0d of %0d beats sent and %0d outputs missing",
                 sent, in_q.size(), exp_q.size());
        run_aborted = 1'b1;
      end
    end
    cdp_rdma2dp_valid = 1'b0;
    nan_preproc_prdy  = 1'b1;
    // no duplicate beat, input closed again
    for (cyc = 0; cyc < settle_cycles && !run_aborted; cyc++) begin
      @(negedge nvdla_core_clk);
      if (nan_preproc_pvld) begin
        $display("[ERROR] %0t: extra output beat %h", $time, nan_preproc_pd);
        err_cnt++;
      end
      if (cdp_rdma2dp_ready) begin
        $display("[ERROR] %0t: input ready high after cube end", $time);
        err_cnt++;
      end
      @(posedge nvdla_core_clk);
      #2;
    end
    in_q.delete();
    exp_q.delete();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int                        fd;
    int                        n;
    int                        errs_before;
    int                        gate_cycles;
    int                        stall;
    logic [7:0]                kind;
    logic [cdp_reg_addr_w-1:0] addr;
    logic [cdp_axi_data_w-1:0] data;
    logic [cdp_axi_data_w-1:0] got_data;
    logic [1:0]                exp_resp;
    logic [1:0]                got_resp;
    logic [cdp_pd_w-1:0]       pd_in;
    logic [cdp_pd_w-1:0]       pd_out;
    nvdla_core_clk    = 1'b0;
    nvdla_core_rstn   = 1'b0;
    awvalid           = 1'b0;
    awaddr            = '0;
    wvalid            = 1'b0;
    wdata             = '0;
    bready            = 1'b0;
    arvalid           = 1'b0;
    araddr            = '0;
    rready            = 1'b0;
    cdp_rdma2dp_valid = 1'b0;
    cdp_rdma2dp_pd    = '0;
    nan_preproc_prdy  = 1'b1;
    lfsr              = 8'd12;
    err_cnt           = 0;
    test_cnt          = 0;
    pass_cnt          = 0;
    fail_cnt          = 0;
    run_aborted       = 1'b0;
    repeat (10) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;

    fd = $fopen("verif/cdp_dp_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file verif/cdp_dp_cases.txt");
      run_aborted = 1'b1;
    end
    while (!run_aborted && $fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": skip_comment(fd);
        "W": begin
          n = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
          errs_before = err_cnt;
          if (n == 3) begin
            write_reg(addr, data, got_resp);
            if (!run_aborted && got_resp !== exp_resp) begin
              $display("[ERROR] %0t: write 0x%02h bresp %0d, expected %0d", $time, addr,
                       got_resp, exp_resp);
              err_cnt++;
            end
          end else begin
            $display("write line in the cases file is malformed");
            run_aborted = 1'b1;
          end
          report_test("write", errs_before);
        end
        "R": begin
          n = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
          errs_before = err_cnt;
          if (n == 3) begin
            read_reg(addr, got_data, got_resp);
            if (!run_aborted && (got_data !== data || got_resp !== exp_resp)) begin
              $display("[ERROR] %0t: read 0x%02h gave %h resp %0d, expected %h resp %0d",
                       $time, addr, got_data, got_resp, data, exp_resp);
              err_cnt++;
            end
          end else begin
            $display("read line in the cases file is malformed");
            run_aborted = 1'b1;
          end
          report_test("read", errs_before);
        end
        "B": begin
          n = $fscanf(fd, "%h %h", pd_in, pd_out);
          if (n == 2) begin
            in_q.push_back(pd_in);
            exp_q.push_back(pd_out);
          end else begin
            $display("beat line in the cases file is malformed");
            run_aborted = 1'b1;
          end
        end
        "L": begin
          n = $fscanf(fd, "%d %d", gate_cycles, stall);
          errs_before = err_cnt;
          if (n == 2 && in_q.size() > 0) begin
            run_layer(gate_cycles, stall);
          end else begin
            $display("layer marker is malformed or has no beats before it");
            run_aborted = 1'b1;
          end
          report_test("layer", errs_before);
        end
        default: begin
          $display("unknown line kind '%c' in the cases file", kind);
          run_aborted = 1'b1;
        end
      endcase
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (in_q.size() != 0) begin
      $display("%0d beats at the end of the cases file have no layer marker", in_q.size());
      err_cnt++;
    end

    $display("tests %0d, passed %0d, failed %0d", test_cnt, pass_cnt, fail_cnt);
    if (err_cnt == 0 && !run_aborted && test_cnt > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/cdp_dp_cases.txt
# W addr wdata bresp | R addr rdata rresp | B in_pd out_pd | L gate_cycles stall (decimal)
# hex values; pd = tag[71:67] last_c last_h last_w data[63:0], element 0 lowest
R 04 00000000 0
W 04 00000001 0
R 04 00000001 0
W 04 00000000 0
R 04 00000000 0
R 14 00000000 2
W 18 00000001 2
W 08 00000005 2
R 08 00000000 0
R 00 00000000 0
# layer 1, nan kept, nan 5 inf 4
B 183C007E007C000001 183C007E007C000001
B 19FE01FC007BFFC000 19FE01FC007BFFC000
B 1B7FFF00007D003555 1B7FFF00007D003555
B 1F7C007C00FFFF1234 1F7C007C00FFFF1234
L 40 1
R 00 00000000 0
R 10 00000001 0
R 08 00000005 0
R 0C 00000004 0
W 10 00000001 0
R 10 00000000 0
# layer 2, nan flushed to zero, nan 7 inf 5
W 04 00000001 0
B 507E007C007E003C00 5000007C0000003C00
B 51FC010400FC008000 5100000400FC008000
B 507C017BFF7C00FE00 5000007BFF7C000000
B 523C003C003C003C00 523C003C003C003C00
B 57FFFFFC007C007E01 570000FC007C000000
L 40 1
R 00 00000000 0
R 10 00000001 0
R 08 00000007 0
R 0C 00000005 0
W 10 00000001 0
R 10 00000000 0
W 08 00000000 2
R 08 00000007 0

// File: sim.f
verilog/cdp_dp_pkg.sv
verilog/cdp_reg_pkg.sv
verilog/cdp_dp_nan.sv
verilog/cdp_dp_nan_count.sv
verilog/cdp_reg_slave.sv
verilog/cdp_dp_top.sv
verif/tb_cdp_dp.sv
